// ==== rtl/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

	// the structs below are fixed at these widths, so REG_W and DATA_W set at
	// hazard_unit must equal them
	localparam int PKG_REG_W  = 5;
	localparam int PKG_DATA_W = 32;

	typedef enum logic [3:0] {
		NOP     = 4'd0,
		CAL_R   = 4'd1,
		CAL_I   = 4'd2,
		LOAD_M  = 4'd3,
		STORE_M = 4'd4,
		CMOV    = 4'd5,
		JUMP_I  = 4'd6,
		JUMP_R  = 4'd7,
		BRANCH  = 4'd8
	} dp_type_e;

	// E2D/M2D/W2D feed decode operands, M2E/W2E execute, W2M memory
	typedef enum logic [3:0] {
		ORIG    = 4'd0,
		E2D_RF  = 4'd1,
		E2D_NPC = 4'd2,
		E2D_MD  = 4'd3,
		M2D_NPC = 4'd4,
		M2D_ALU = 4'd5,
		M2D_MD  = 4'd6,
		W2D_RF  = 4'd7,
		M2E_NPC = 4'd8,
		M2E_ALU = 4'd9,
		M2E_MD  = 4'd10,
		W2E_RF  = 4'd11,
		W2M_RF  = 4'd12
	} fwd_src_e;

	typedef struct packed {
		dp_type_e               dptype;
		logic [PKG_REG_W-1:0]   reg1;
		logic [PKG_REG_W-1:0]   reg2;
		logic [PKG_REG_W-1:0]   regw;
	} instr_desc_t;

	typedef struct packed {
		logic [PKG_DATA_W-1:0]  e_rf;
		logic [PKG_DATA_W-1:0]  e_npc;
		logic [PKG_DATA_W-1:0]  e_md;
		logic [PKG_DATA_W-1:0]  m_alu;
		logic [PKG_DATA_W-1:0]  m_npc;
		logic [PKG_DATA_W-1:0]  m_md;
		logic [PKG_DATA_W-1:0]  w_rf;
	} stage_vals_t;

	typedef struct packed {
		logic [PKG_DATA_W-1:0]  d_op1;
		logic [PKG_DATA_W-1:0]  d_op2;
		logic [PKG_DATA_W-1:0]  e_op1;
		logic [PKG_DATA_W-1:0]  e_op2;
		logic [PKG_DATA_W-1:0]  m_op2;
	} raw_ops_t;

	typedef struct packed {
		fwd_src_e fm_d1;
		fwd_src_e fm_d2;
		fwd_src_e fm_e1;
		fwd_src_e fm_e2;
		fwd_src_e fm_m;
	} fwd_ctl_t;

	// register zero is hardwired, so a write to it is never a producer
	function automatic logic fwable(
		input logic [PKG_REG_W-1:0] src,
		input logic [PKG_REG_W-1:0] dst
	);
		return (src != '0) && (src == dst);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/stage_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  hazard_pkg::instr_desc_t d_desc,
	input  logic                    stall,
	output hazard_pkg::instr_desc_t e_desc,
	output hazard_pkg::instr_desc_t m_desc,
	output hazard_pkg::instr_desc_t w_desc
);

	localparam hazard_pkg::instr_desc_t BUBBLE = '{
		dptype: hazard_pkg::NOP,
		reg1:   '0,
		reg2:   '0,
		regw:   '0
	};

	hazard_pkg::instr_desc_t e_next;

	// decode holds its instruction during a stall, so E sees a bubble instead
	always_comb begin
		if (stall) begin
			e_next = BUBBLE;
		end else begin
			e_next = d_desc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_desc <= BUBBLE;
		end else begin
			e_desc <= e_next;
		end
	end

	// M and W keep advancing, which lets the stalled producer drain into M
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_desc <= BUBBLE;
			w_desc <= BUBBLE;
		end else begin
			m_desc <= e_desc;
			w_desc <= m_desc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/load_use_stall.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_use_stall #(
	parameter int REG_W = 5
) (
	input  hazard_pkg::instr_desc_t d_desc,
	input  hazard_pkg::instr_desc_t e_desc,
	output logic                    stall
);

	logic [REG_W-1:0] d_r1;
	logic [REG_W-1:0] d_r2;
	logic [REG_W-1:0] e_rw;
	logic             e_is_alu;
	logic             d_needs_e;

	assign d_r1 = d_desc.reg1;
	assign d_r2 = d_desc.reg2;
	assign e_rw = e_desc.regw;

	// an ALU result in E has no path back to decode, it becomes usable from M
	assign e_is_alu = (e_desc.dptype == hazard_pkg::CAL_R) ||
		(e_desc.dptype == hazard_pkg::CAL_I);

	assign d_needs_e = hazard_pkg::fwable(d_r1, e_rw) ||
		hazard_pkg::fwable(d_r2, e_rw);

	assign stall = e_is_alu && d_needs_e;

endmodule

`default_nettype wire

// ==== rtl/forward_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_select #(
	parameter int REG_W = 5
) (
	input  hazard_pkg::instr_desc_t d_desc,
	input  hazard_pkg::instr_desc_t e_desc,
	input  hazard_pkg::instr_desc_t m_desc,
	input  hazard_pkg::instr_desc_t w_desc,
	output hazard_pkg::fwd_ctl_t    fwd_ctl
);

	logic [REG_W-1:0]     d_r1;
	logic [REG_W-1:0]     d_r2;
	logic [REG_W-1:0]     e_r1;
	logic [REG_W-1:0]     e_r2;
	logic [REG_W-1:0]     m_r2;
	logic [REG_W-1:0]     e_rw;
	logic [REG_W-1:0]     m_rw;
	logic [REG_W-1:0]     w_rw;
	hazard_pkg::dp_type_e e_type;
	hazard_pkg::dp_type_e m_type;

	function automatic logic is_jump(input hazard_pkg::dp_type_e t);
		return (t == hazard_pkg::JUMP_I) || (t == hazard_pkg::JUMP_R);
	endfunction

	function automatic logic is_alu(input hazard_pkg::dp_type_e t);
		return (t == hazard_pkg::CAL_R) || (t == hazard_pkg::CAL_I) ||
			(t == hazard_pkg::CMOV);
	endfunction

	// M then W part of the chain, returned in the decode form of the code
	function automatic hazard_pkg::fwd_src_e mw_sel(
		input logic [REG_W-1:0]     src,
		input logic [REG_W-1:0]     m_dst,
		input hazard_pkg::dp_type_e m_kind,
		input logic [REG_W-1:0]     w_dst
	);
		if (hazard_pkg::fwable(src, m_dst) && is_jump(m_kind)) begin
			return hazard_pkg::M2D_NPC;
		end else if (hazard_pkg::fwable(src, m_dst) && is_alu(m_kind)) begin
			return hazard_pkg::M2D_ALU;
		end else if (hazard_pkg::fwable(src, m_dst) && m_kind == hazard_pkg::LOAD_M) begin
			return hazard_pkg::M2D_MD;
		end else if (hazard_pkg::fwable(src, w_dst)) begin
			return hazard_pkg::W2D_RF;
		end
		return hazard_pkg::ORIG;
	endfunction

	function automatic hazard_pkg::fwd_src_e d_sel(
		input logic [REG_W-1:0]     src,
		input logic [REG_W-1:0]     e_dst,
		input hazard_pkg::dp_type_e e_kind,
		input logic [REG_W-1:0]     m_dst,
		input hazard_pkg::dp_type_e m_kind,
		input logic [REG_W-1:0]     w_dst
	);
		// E-stage ALU producers are left out here, they stall decode instead
		if (hazard_pkg::fwable(src, e_dst) && e_kind == hazard_pkg::CMOV) begin
			return hazard_pkg::E2D_RF;
		end else if (hazard_pkg::fwable(src, e_dst) && is_jump(e_kind)) begin
			return hazard_pkg::E2D_NPC;
		end else if (hazard_pkg::fwable(src, e_dst) && e_kind == hazard_pkg::LOAD_M) begin
			return hazard_pkg::E2D_MD;
		end
		return mw_sel(src, m_dst, m_kind, w_dst);
	endfunction

	// execute operands see the same M and W producers under their own codes
	function automatic hazard_pkg::fwd_src_e to_e_code(input hazard_pkg::fwd_src_e code);
		case (code)
			hazard_pkg::M2D_NPC: return hazard_pkg::M2E_NPC;
			hazard_pkg::M2D_ALU: return hazard_pkg::M2E_ALU;
			hazard_pkg::M2D_MD:  return hazard_pkg::M2E_MD;
			hazard_pkg::W2D_RF:  return hazard_pkg::W2E_RF;
			default:             return hazard_pkg::ORIG;
		endcase
	endfunction

	assign d_r1   = d_desc.reg1;
	assign d_r2   = d_desc.reg2;
	assign e_r1   = e_desc.reg1;
	assign e_r2   = e_desc.reg2;
	assign m_r2   = m_desc.reg2;
	assign e_rw   = e_desc.regw;
	assign m_rw   = m_desc.regw;
	assign w_rw   = w_desc.regw;
	assign e_type = e_desc.dptype;
	assign m_type = m_desc.dptype;

	always_comb begin
		fwd_ctl.fm_d1 = d_sel(d_r1, e_rw, e_type, m_rw, m_type, w_rw);
		fwd_ctl.fm_d2 = d_sel(d_r2, e_rw, e_type, m_rw, m_type, w_rw);
		fwd_ctl.fm_e1 = to_e_code(mw_sel(e_r1, m_rw, m_type, w_rw));
		fwd_ctl.fm_e2 = to_e_code(mw_sel(e_r2, m_rw, m_type, w_rw));
		// only the store data operand is still read in M
		if (hazard_pkg::fwable(m_r2, w_rw)) begin
			fwd_ctl.fm_m = hazard_pkg::W2M_RF;
		end else begin
			fwd_ctl.fm_m = hazard_pkg::ORIG;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass #(
	parameter int DATA_W = 32
) (
	input  hazard_pkg::fwd_ctl_t    fwd_ctl,
	input  hazard_pkg::raw_ops_t    raw_ops,
	input  hazard_pkg::stage_vals_t stage_vals,
	output hazard_pkg::raw_ops_t    fwd_ops
);

	// codes that name the same stage result share an arm, whatever operand they feed
	function automatic logic [DATA_W-1:0] pick(
		input hazard_pkg::fwd_src_e    sel,
		input logic [DATA_W-1:0]       raw,
		input hazard_pkg::stage_vals_t sv
	);
		case (sel)
			hazard_pkg::E2D_RF: begin
				return sv.e_rf;
			end
			hazard_pkg::E2D_NPC: begin
				return sv.e_npc;
			end
			hazard_pkg::E2D_MD: begin
				return sv.e_md;
			end
			hazard_pkg::M2D_NPC, hazard_pkg::M2E_NPC: begin
				return sv.m_npc;
			end
			hazard_pkg::M2D_ALU, hazard_pkg::M2E_ALU: begin
				return sv.m_alu;
			end
			hazard_pkg::M2D_MD, hazard_pkg::M2E_MD: begin
				return sv.m_md;
			end
			hazard_pkg::W2D_RF, hazard_pkg::W2E_RF, hazard_pkg::W2M_RF: begin
				return sv.w_rf;
			end
			default: begin
				return raw;
			end
		endcase
	endfunction

	always_comb begin
		fwd_ops.d_op1 = pick(fwd_ctl.fm_d1, raw_ops.d_op1, stage_vals);
		fwd_ops.d_op2 = pick(fwd_ctl.fm_d2, raw_ops.d_op2, stage_vals);
		fwd_ops.e_op1 = pick(fwd_ctl.fm_e1, raw_ops.e_op1, stage_vals);
		fwd_ops.e_op2 = pick(fwd_ctl.fm_e2, raw_ops.e_op2, stage_vals);
		fwd_ops.m_op2 = pick(fwd_ctl.fm_m, raw_ops.m_op2, stage_vals);
	end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit #(
	parameter int REG_W  = 5,
	parameter int DATA_W = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  hazard_pkg::instr_desc_t d_desc,
	input  hazard_pkg::stage_vals_t stage_vals,
	input  hazard_pkg::raw_ops_t    raw_ops,
	output logic                    stall,
	output hazard_pkg::raw_ops_t    fwd_ops
);

	hazard_pkg::instr_desc_t e_desc;
	hazard_pkg::instr_desc_t m_desc;
	hazard_pkg::instr_desc_t w_desc;
	hazard_pkg::fwd_ctl_t    fwd_ctl;

	stage_tracker u_stage_tracker (
		.clk    (clk),
		.rst_n  (rst_n),
		.d_desc (d_desc),
		.stall  (stall),
		.e_desc (e_desc),
		.m_desc (m_desc),
		.w_desc (w_desc)
	);

	load_use_stall #(
		.REG_W (REG_W)
	) u_load_use_stall (
		.d_desc (d_desc),
		.e_desc (e_desc),
		.stall  (stall)
	);

	forward_select #(
		.REG_W (REG_W)
	) u_forward_select (
		.d_desc  (d_desc),
		.e_desc  (e_desc),
		.m_desc  (m_desc),
		.w_desc  (w_desc),
		.fwd_ctl (fwd_ctl)
	);

	// selections and muxes are combinational, operands follow the same cycle
	operand_bypass #(
		.DATA_W (DATA_W)
	) u_operand_bypass (
		.fwd_ctl    (fwd_ctl),
		.raw_ops    (raw_ops),
		.stage_vals (stage_vals),
		.fwd_ops    (fwd_ops)
	);

endmodule

`default_nettype wire

// ==== verif/tb_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hazard_unit;

	localparam int REG_W    = 5;
	localparam int DATA_W   = 32;
	localparam int N_CYCLES = 2000;
	localparam int WATCHDOG = N_CYCLES + 100;

	localparam hazard_pkg::instr_desc_t BUBBLE = '{
		dptype: hazard_pkg::NOP,
		reg1:   '0,
		reg2:   '0,
		regw:   '0
	};

	logic                    clk;
	logic                    rst_n;
	hazard_pkg::instr_desc_t d_desc;
	hazard_pkg::stage_vals_t stage_vals;
	hazard_pkg::raw_ops_t    raw_ops;
	logic                    stall;
	hazard_pkg::raw_ops_t    fwd_ops;

	// shadow of the E, M and W descriptors
	hazard_pkg::instr_desc_t sh_e;
	hazard_pkg::instr_desc_t sh_m;
	hazard_pkg::instr_desc_t sh_w;
	hazard_pkg::raw_ops_t    exp_ops;
	logic                    exp_stall;
	logic                    was_stalled;
	int                      n_stall;
	int                      n_efwd;

	hazard_unit #(
		.REG_W  (REG_W),
		.DATA_W (DATA_W)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.d_desc     (d_desc),
		.stage_vals (stage_vals),
		.raw_ops    (raw_ops),
		.stall      (stall),
		.fwd_ops    (fwd_ops)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic logic hits(input logic [REG_W-1:0] src, input logic [REG_W-1:0] dst);
		return (src != '0) && (src == dst);
	endfunction

	function automatic logic [DATA_W-1:0] from_m_or_w(
		input logic [REG_W-1:0]      src,
		input logic [DATA_W-1:0]     raw,
		input hazard_pkg::instr_desc_t m,
		input hazard_pkg::instr_desc_t w,
		input hazard_pkg::stage_vals_t sv
	);
		if (hits(src, m.regw)) begin
			case (m.dptype)
				hazard_pkg::JUMP_I, hazard_pkg::JUMP_R: return sv.m_npc;
				hazard_pkg::CAL_R, hazard_pkg::CAL_I, hazard_pkg::CMOV: return sv.m_alu;
				hazard_pkg::LOAD_M: return sv.m_md;
				default: ;
			endcase
		end
		if (hits(src, w.regw)) begin
			return sv.w_rf;
		end
		return raw;
	endfunction

	// nearest producer wins, an ALU op in E is covered by the stall instead
	function automatic logic [DATA_W-1:0] decode_operand(
		input logic [REG_W-1:0]      src,
		input logic [DATA_W-1:0]     raw,
		input hazard_pkg::instr_desc_t e,
		input hazard_pkg::instr_desc_t m,
		input hazard_pkg::instr_desc_t w,
		input hazard_pkg::stage_vals_t sv
	);
		if (hits(src, e.regw)) begin
			case (e.dptype)
				hazard_pkg::CMOV: return sv.e_rf;
				hazard_pkg::JUMP_I, hazard_pkg::JUMP_R: return sv.e_npc;
				hazard_pkg::LOAD_M: return sv.e_md;
				default: ;
			endcase
		end
		return from_m_or_w(src, raw, m, w, sv);
	endfunction

	function automatic logic expect_stall(
		input hazard_pkg::instr_desc_t d,
		input hazard_pkg::instr_desc_t e
	);
		return ((e.dptype == hazard_pkg::CAL_R) || (e.dptype == hazard_pkg::CAL_I)) &&
			(hits(d.reg1, e.regw) || hits(d.reg2, e.regw));
	endfunction

	function automatic logic e_feeds_decode(
		input hazard_pkg::instr_desc_t d,
		input hazard_pkg::instr_desc_t e
	);
		return (e.dptype == hazard_pkg::CMOV || e.dptype == hazard_pkg::JUMP_I ||
			e.dptype == hazard_pkg::JUMP_R || e.dptype == hazard_pkg::LOAD_M) &&
			(hits(d.reg1, e.regw) || hits(d.reg2, e.regw));
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "stopping on the first failure");
	endtask

	task automatic check_value(
		input string             what,
		input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp
	);
		assert (got === exp) else begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic drive_inputs(input logic hold);
		logic [3:0] kind;
		if (!hold) begin
			kind = 4'($urandom_range(8, 0));
			d_desc.dptype = hazard_pkg::dp_type_e'(kind);
			// indices 0 to 3 keep producers and consumers colliding often
			d_desc.reg1 = REG_W'($urandom_range(3, 0));
			d_desc.reg2 = REG_W'($urandom_range(3, 0));
			d_desc.regw = REG_W'($urandom_range(3, 0));
		end
		stage_vals.e_rf  = $urandom();
		stage_vals.e_npc = $urandom();
		stage_vals.e_md  = $urandom();
		stage_vals.m_alu = $urandom();
		stage_vals.m_npc = $urandom();
		stage_vals.m_md  = $urandom();
		stage_vals.w_rf  = $urandom();
		raw_ops.d_op1    = $urandom();
		raw_ops.d_op2    = $urandom();
		raw_ops.e_op1    = $urandom();
		raw_ops.e_op2    = $urandom();
		raw_ops.m_op2    = $urandom();
	endtask

	task automatic check_cycle();
		exp_stall = expect_stall(d_desc, sh_e);
		exp_ops.d_op1 = decode_operand(d_desc.reg1, raw_ops.d_op1, sh_e, sh_m, sh_w, stage_vals);
		exp_ops.d_op2 = decode_operand(d_desc.reg2, raw_ops.d_op2, sh_e, sh_m, sh_w, stage_vals);
		exp_ops.e_op1 = from_m_or_w(sh_e.reg1, raw_ops.e_op1, sh_m, sh_w, stage_vals);
		exp_ops.e_op2 = from_m_or_w(sh_e.reg2, raw_ops.e_op2, sh_m, sh_w, stage_vals);
		exp_ops.m_op2 = hits(sh_m.reg2, sh_w.regw) ? stage_vals.w_rf : raw_ops.m_op2;
		check_value("E descriptor", dut.e_desc, sh_e);
		check_value("M descriptor", dut.m_desc, sh_m);
		check_value("W descriptor", dut.w_desc, sh_w);
		check_value("d_op1", fwd_ops.d_op1, exp_ops.d_op1);
		check_value("d_op2", fwd_ops.d_op2, exp_ops.d_op2);
		check_value("e_op1", fwd_ops.e_op1, exp_ops.e_op1);
		check_value("e_op2", fwd_ops.e_op2, exp_ops.e_op2);
		check_value("m_op2", fwd_ops.m_op2, exp_ops.m_op2);
		if (exp_stall) begin
			n_stall++;
		end
		if (e_feeds_decode(d_desc, sh_e)) begin
			n_efwd++;
		end
	endtask

	// stall is sampled at the edge that closes each checked cycle
	assert property (@(posedge clk) disable iff (!rst_n) stall === exp_stall)
	else begin
		$display("ERR %0t ns: stall is %b, expected %b", $time,
			$sampled(stall), $sampled(exp_stall));
		abort_run();
	end

	initial begin
		int unsigned seed_init;
		int          cyc;
		seed_init   = $urandom(32'h7df1);
		rst_n       = 1'b0;
		d_desc      = BUBBLE;
		stage_vals  = '0;
		raw_ops     = '0;
		sh_e        = BUBBLE;
		sh_m        = BUBBLE;
		sh_w        = BUBBLE;
		exp_ops     = '0;
		exp_stall   = 1'b0;
		was_stalled = 1'b0;
		n_stall     = 0;
		n_efwd      = 0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (cyc = 0; cyc < N_CYCLES; cyc++) begin
			drive_inputs(was_stalled);
			#4;
			check_cycle();
			was_stalled = exp_stall;
			@(posedge clk);
			sh_w = sh_m;
			sh_m = sh_e;
			if (was_stalled) begin
				sh_e = BUBBLE;
			end else begin
				sh_e = d_desc;
			end
			#1;
		end
		if (n_stall > 0 && n_efwd > 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("the random stream never produced both a stall and an E-stage bypass");
			abort_run();
		end
	end

	initial begin
		int waited;
		waited = 0;
		while (waited < WATCHDOG) begin
			@(posedge clk);
			waited++;
		end
		$display("timeout: the stimulus loop did not finish within %0d cycles", WATCHDOG);
		abort_run();
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/hazard_pkg.sv
rtl/stage_tracker.sv
rtl/load_use_stall.sv
rtl/forward_select.sv
rtl/operand_bypass.sv
rtl/hazard_unit.sv
verif/tb_hazard_unit.sv

// ==== Bender.yml ====
package:
  name: hazard_unit

sources:
  - rtl/hazard_pkg.sv
  - rtl/stage_tracker.sv
  - rtl/load_use_stall.sv
  - rtl/forward_select.sv
  - rtl/operand_bypass.sv
  - rtl/hazard_unit.sv
  - target: test
    files:
      - verif/tb_hazard_unit.sv
